/* verilog/aux_audio_pkg.sv */
// Auxiliary audio path shared types, rate and buffer constants

package aux_audio_pkg;

  ////////////////////////////////////////
  // Sample and memory types
  ////////////////////////////////////////

  typedef logic signed [15:0] sample_t;  // One signed PCM sample

  typedef struct packed {
    sample_t left;   // Upper half of the pair
    sample_t right;  // Lower half
  } stereo_t;

  typedef logic [15:0] mem_word_t;    // Word as stored in memory
  typedef logic [22:0] mem_addr_t;    // Word address toward memory
  typedef logic [15:0] buf_offset_t;  // Offset inside the 64K-word window

  ////////////////////////////////////////
  // Sample rate pacing
  ////////////////////////////////////////

  localparam int unsigned SAMPLE_DIV   = 2572;  // clk_114 cycles per sample period
  localparam int unsigned RATE_W       = 12;    // Pacing counter width
  localparam int unsigned RIGHT_OFFSET = 4;     // Left pop to right pop distance

  ////////////////////////////////////////
  // Word buffer and burst fetch
  ////////////////////////////////////////

  localparam int unsigned FIFO_DEPTH  = 16;                       // Buffered words
  localparam int unsigned FIFO_PTR_W  = $clog2(FIFO_DEPTH);       // Read/write pointer width
  localparam int unsigned FIFO_CNT_W  = $clog2(FIFO_DEPTH + 1);   // Fill level 0..DEPTH
  localparam int unsigned BURST_LEN   = 4;                        // Words per request
  localparam int unsigned BURST_CNT_W = $clog2(BURST_LEN);        // Fill strobe counter

  // Window sits at page 0x30 of SDRAM, word offset below it
  localparam logic [6:0] AUX_PAGE = 7'b0110000;

endpackage

/* verilog/aux_sample_fifo.sv */
// Streaming sample word buffer, fetches bursts from a wrapping 64K-word memory window

`timescale 1ns/1ps

module aux_sample_fifo (
  input  logic                     clk_114,
  input  logic                     rst,
  input  logic                     enable,       // Low holds buffer empty, offset at 0
  input  logic                     pop,          // One word consumed
  input  logic                     mem_fill,     // One word from memory
  input  aux_audio_pkg::mem_word_t mem_data,
  output aux_audio_pkg::mem_word_t q,            // Show-ahead head word
  output logic                     empty,
  output logic                     mem_req,      // Burst request, held until last fill
  output aux_audio_pkg::mem_addr_t mem_addr,
  output logic                     buffer_half   // Which half of window is being fetched
);

  import aux_audio_pkg::*;

  mem_word_t              store [FIFO_DEPTH];  // Circular word store
  logic [FIFO_PTR_W-1:0]  wr_ptr;
  logic [FIFO_PTR_W-1:0]  rd_ptr;
  logic [FIFO_CNT_W-1:0]  count;               // Words held
  logic [BURST_CNT_W-1:0] fill_cnt;            // Fills seen in open burst
  buf_offset_t            offset;              // Fetch offset of current/next burst
  logic                   burst_drop;          // Open burst belongs to a disabled stream
  logic                   wr_en;
  logic                   rd_en;
  logic                   last_fill;
  logic                   room;
  logic                   start_burst;

  ////////////////////////////////////////
  // Strobes
  ////////////////////////////////////////

  assign wr_en       = mem_fill && mem_req && enable && !burst_drop;  // Keep only live words
  assign rd_en       = pop && !empty;
  assign last_fill   = mem_req && mem_fill && (fill_cnt == BURST_CNT_W'(BURST_LEN - 1));
  assign room        = count <= FIFO_CNT_W'(FIFO_DEPTH - BURST_LEN);  // Whole burst fits
  assign start_burst = enable && !mem_req && room;

  ////////////////////////////////////////
  // Word store and fill level
  ////////////////////////////////////////

  always_ff @(posedge clk_114) begin
    if (wr_en) begin
      store[wr_ptr] <= mem_data;  // No reset on payload
    end
  end

  always_ff @(posedge clk_114) begin
    if (rst || !enable) begin
      wr_ptr <= '0;  // Disabled stream is flushed
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;  // Wraps at FIFO_DEPTH
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle or simultaneous write and read
      endcase
    end
  end

  ////////////////////////////////////////
  // Burst request and fetch offset
  ////////////////////////////////////////

  always_ff @(posedge clk_114) begin
    if (rst) begin
      mem_req    <= 1'b0;
      fill_cnt   <= '0;
      burst_drop <= 1'b0;
      offset     <= '0;
    end else begin
      if (!mem_req) begin
        fill_cnt <= '0;
        if (start_burst) begin
          mem_req    <= 1'b1;  // Address already stable
          burst_drop <= 1'b0;
        end
      end else if (mem_fill) begin
        fill_cnt <= fill_cnt + 1'b1;
        if (last_fill) begin
          mem_req <= 1'b0;  // Drops the cycle after last fill
          if (enable && !burst_drop) begin
            offset <= offset + buf_offset_t'(BURST_LEN);  // Wraps inside window
          end
        end
      end
      // Remaining fills of an open burst are swallowed
      if (!enable) begin
        burst_drop <= 1'b1;
        offset     <= '0;
      end
    end
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  assign q           = store[rd_ptr];     // Valid while not empty
  assign empty       = (count == '0);
  assign mem_addr    = {AUX_PAGE, offset};
  assign buffer_half = offset[15];        // Tells software which half is free

endmodule

/* verilog/aux_sample_sequencer.sv */
// Sample rate pacer, pops left then right word, byte-swaps and holds the stereo pair

`timescale 1ns/1ps

module aux_sample_sequencer (
  input  logic                     clk_114,
  input  logic                     rst,
  input  aux_audio_pkg::mem_word_t q,      // Show-ahead buffer head
  input  logic                     empty,
  output logic                     pop,    // One-cycle strobe per slot
  output aux_audio_pkg::stereo_t   aux     // Held auxiliary pair
);

  import aux_audio_pkg::*;

  logic [RATE_W-1:0] rate_cnt;    // Position inside sample period
  logic              left_slot;
  logic              right_slot;
  logic              period_end;
  sample_t           swapped;     // Little-endian word turned native

  ////////////////////////////////////////
  // Sample period pacing
  ////////////////////////////////////////

  assign period_end = (rate_cnt == RATE_W'(SAMPLE_DIV - 1));
  assign left_slot  = (rate_cnt == '0);                    // First word of a pair
  assign right_slot = (rate_cnt == RATE_W'(RIGHT_OFFSET)); // Second word

  always_ff @(posedge clk_114) begin
    if (rst) begin
      rate_cnt <= '0;
    end else if (period_end) begin
      rate_cnt <= '0;
    end else begin
      rate_cnt <= rate_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Word fetch and channel hold
  ////////////////////////////////////////

  // Underflow plays silence rather than stale data
  assign swapped = empty ? '0 : sample_t'({q[7:0], q[15:8]});
  assign pop     = (left_slot || right_slot) && !empty;  // Never pops an empty buffer

  always_ff @(posedge clk_114) begin
    if (rst) begin
      aux <= '0;
    end else begin
      if (left_slot) begin
        aux.left <= swapped;   // Visible the cycle after slot
      end
      if (right_slot) begin
        aux.right <= swapped;
      end
    end
  end

endmodule

/* verilog/audio_mixer.sv */
// Stereo mixer, saturating signed sum of native and auxiliary pairs, registered

`timescale 1ns/1ps

module audio_mixer (
  input  logic                   clk_114,
  input  logic                   rst,
  input  aux_audio_pkg::stereo_t native,  // Chipset audio
  input  aux_audio_pkg::stereo_t aux,     // Streamed audio
  output aux_audio_pkg::stereo_t mixed
);

  import aux_audio_pkg::*;

  stereo_t mix_next;

  // One bit of headroom, then clamp back to 16 bits
  function automatic sample_t sat_add(input sample_t a, input sample_t b);
    logic signed [16:0] sum;
    sum = a + b;  // Sign-extended into 17 bits
    if (sum[16] != sum[15]) begin
      sat_add = sum[16] ? sample_t'(16'sh8000) : sample_t'(16'sh7fff);  // Clip
    end else begin
      sat_add = sample_t'(sum[15:0]);
    end
  endfunction

  ////////////////////////////////////////
  // Per-channel sum and output register
  ////////////////////////////////////////

  assign mix_next.left  = sat_add(native.left, aux.left);
  assign mix_next.right = sat_add(native.right, aux.right);

  always_ff @(posedge clk_114) begin
    if (rst) begin
      mixed <= '0;
    end else begin
      mixed <= mix_next;  // One cycle after inputs
    end
  end

endmodule

/* verilog/sigma_delta_dac.sv */
// First-order sigma-delta DAC channel, signed sample to one-bit density stream

`timescale 1ns/1ps

module sigma_delta_dac (
  input  logic                   clk_114,
  input  logic                   rst,
  input  aux_audio_pkg::sample_t sample,   // Two's complement input
  output logic                   bit_out   // Ones density is u/65536
);

  logic [15:0] u;      // Offset-binary level
  logic [15:0] acc;    // Error accumulator
  logic [16:0] sum;    // Carry is the output bit

  ////////////////////////////////////////
  // Offset conversion and accumulate
  ////////////////////////////////////////

  // Most negative sample maps to 0, most positive to 0xffff
  assign u   = {~sample[15], sample[14:0]};
  assign sum = {1'b0, acc} + {1'b0, u};

  always_ff @(posedge clk_114) begin
    if (rst) begin
      acc     <= '0;
      bit_out <= 1'b0;  // Quiet line out of reset
    end else begin
      acc     <= sum[15:0];  // Residue carried forward
      bit_out <= sum[16];    // Overflow marks a one
    end
  end

endmodule

/* verilog/aux_audio_top.sv */
// Auxiliary audio path top, buffer to sequencer to mixer to two sigma-delta channels

`timescale 1ns/1ps

module aux_audio_top (
  input  logic                     clk_114,
  input  logic                     rst,
  input  logic                     aux_enable,    // Software stream enable
  input  aux_audio_pkg::sample_t   native_left,   // Chipset left
  input  aux_audio_pkg::sample_t   native_right,  // Chipset right
  input  logic                     mem_fill,      // Memory word strobe
  input  aux_audio_pkg::mem_word_t mem_data,
  output logic                     mem_req,       // Burst request
  output aux_audio_pkg::mem_addr_t mem_addr,
  output logic                     buffer_half,   // Half flag for the player
  output logic                     audio_l,       // Left bitstream
  output logic                     audio_r        // Right bitstream
);

  import aux_audio_pkg::*;

  mem_word_t fifo_q;      // Head word of buffer
  logic      fifo_empty;
  logic      fifo_pop;
  stereo_t   native;      // Chipset pair
  stereo_t   aux_pair;    // Held streamed pair
  stereo_t   mixed;       // Saturated sum

  assign native = '{left: native_left, right: native_right};

  ////////////////////////////////////////
  // Fetch and pacing
  ////////////////////////////////////////

  aux_sample_fifo u_fifo (
    .clk_114     (clk_114),
    .rst         (rst),
    .enable      (aux_enable),
    .pop         (fifo_pop),
    .mem_fill    (mem_fill),
    .mem_data    (mem_data),
    .q           (fifo_q),
    .empty       (fifo_empty),
    .mem_req     (mem_req),
    .mem_addr    (mem_addr),
    .buffer_half (buffer_half)
  );

  aux_sample_sequencer u_seq (
    .clk_114 (clk_114),
    .rst     (rst),
    .q       (fifo_q),
    .empty   (fifo_empty),
    .pop     (fifo_pop),
    .aux     (aux_pair)
  );

  ////////////////////////////////////////
  // Mix and convert
  ////////////////////////////////////////

  audio_mixer u_mix (
    .clk_114 (clk_114),
    .rst     (rst),
    .native  (native),
    .aux     (aux_pair),
    .mixed   (mixed)
  );

  sigma_delta_dac u_dac_l (
    .clk_114 (clk_114),
    .rst     (rst),
    .sample  (mixed.left),
    .bit_out (audio_l)
  );

  sigma_delta_dac u_dac_r (
    .clk_114 (clk_114),
    .rst     (rst),
    .sample  (mixed.right),
    .bit_out (audio_r)
  );

endmodule

/* test/aux_audio_assert.sv */
// Bound assertions on the memory strobes and the reset state of the audio path

`timescale 1ns/1ps

module aux_audio_assert (
  input logic                     clk_114,
  input logic                     rst,
  input logic                     mem_req,
  input logic                     mem_fill,
  input aux_audio_pkg::mem_addr_t mem_addr,
  input logic                     audio_l,
  input logic                     audio_r
);

  int fail_count = 0;  // Failed assertions, summed into the testbench result

  ////////////////////////////////////////
  // Memory request protocol
  ////////////////////////////////////////

  addr_stable: assert property (@(posedge clk_114) disable iff (rst)
    mem_req |=> (!mem_req || $stable(mem_addr)))  // Held for the whole burst
    else begin
      $error("mem_addr changed while mem_req was high");
      fail_count++;
    end

  fill_in_burst: assert property (@(posedge clk_114) disable iff (rst)
    mem_fill |-> mem_req)  // Fills only answer an open request
    else begin
      $error("mem_fill seen without mem_req");
      fail_count++;
    end

  ////////////////////////////////////////
  // Reset state
  ////////////////////////////////////////

  reset_quiet: assert property (@(posedge clk_114)
    rst |=> (!mem_req && !audio_l && !audio_r))
    else begin
      $error("mem_req or audio outputs high after reset");
      fail_count++;
    end

endmodule

bind aux_audio_top aux_audio_assert u_assert (
  .clk_114  (clk_114),
  .rst      (rst),
  .mem_req  (mem_req),
  .mem_fill (mem_fill),
  .mem_addr (mem_addr),
  .audio_l  (audio_l),
  .audio_r  (audio_r)
);

/* test/aux_audio_tb.sv */
// Testbench for the auxiliary audio path, memory model, density checks and watchdog

`timescale 1ns/1ps

module aux_audio_tb;

  import aux_audio_pkg::*;

  localparam int K_PERIODS   = 16;                         // Pace window in sample periods
  // Cycle budget per test, reset + t1 + t4 + t2 + t3 + t5
  localparam int TEST_CYCLES = 10 + 1 * int'(SAMPLE_DIV) + 9 * int'(SAMPLE_DIV) + 200
                               + K_PERIODS * int'(SAMPLE_DIV) + 10 * int'(SAMPLE_DIV) + 100;
  localparam int WATCHDOG_NS = TEST_CYCLES * 4 * 12 / 10;  // 4 ns period, 20 percent slack
  localparam mem_word_t MIX_WORD = 16'h0040;               // Swaps to 0x4000

  logic      clk_114 = 1'b0;
  logic      rst;
  logic      aux_enable;
  sample_t   native_left;
  sample_t   native_right;
  logic      mem_fill = 1'b0;
  mem_word_t mem_data = '0;
  logic      mem_req;
  mem_addr_t mem_addr;
  logic      buffer_half;
  logic      audio_l;
  logic      audio_r;

  integer      seed      = 32'h2a;
  int          errors    = 0;
  int          checks    = 0;
  int          req_count = 0;   // Requests seen by memory model
  int          req_done  = 0;   // Bursts fully delivered
  buf_offset_t exp_off   = '0;  // Offset the next request should carry
  mem_word_t   fill_word = 16'h1234;

  always #2 clk_114 = ~clk_114;  // 4 ns period

  aux_audio_top DUT (
    .clk_114      (clk_114),
    .rst          (rst),
    .aux_enable   (aux_enable),
    .native_left  (native_left),
    .native_right (native_right),
    .mem_fill     (mem_fill),
    .mem_data     (mem_data),
    .mem_req      (mem_req),
    .mem_addr     (mem_addr),
    .buffer_half  (buffer_half),
    .audio_l      (audio_l),
    .audio_r      (audio_r)
  );

  ////////////////////////////////////////
  // Reference functions
  ////////////////////////////////////////

  function automatic int rand_range(input int lo, input int hi);
    logic [31:0] r;
    r = $random(seed);
    return lo + int'(r % 32'(hi - lo + 1));
  endfunction

  // Memory holds little-endian samples
  function automatic sample_t byte_swap(input mem_word_t w);
    int lo_byte;
    int hi_byte;
    lo_byte = int'(w) % 256;
    hi_byte = int'(w) / 256;
    return sample_t'(lo_byte * 256 + hi_byte);  // Low byte moves to the top
  endfunction

  function automatic int sat_sum(input int a, input int b);
    int s;
    s = a + b;
    if (s > 32767) begin
      s = 32767;
    end else if (s < -32768) begin
      s = -32768;
    end
    return s;
  endfunction

  // Ones over a window, window * u / 65536 with u offset binary
  function automatic int expected_ones(input sample_t s, input int cycles);
    longint u;
    u = longint'(s) + 64'sd32768;
    return int'((longint'(cycles) * u) / 64'sd65536);
  endfunction

  ////////////////////////////////////////
  // Compare and measure
  ////////////////////////////////////////

  task automatic check_value(input string name, input int got, input int exp, input int tol);
    checks++;
    if (got > exp + tol || got < exp - tol) begin
      errors++;
      $display("error: t=%0t %s got %0d (0x%0h) expected %0d (0x%0h) tolerance %0d",
               $time, name, got, got, exp, exp, tol);
    end
  endtask

  task automatic count_ones(input int cycles, output int ones_l, output int ones_r);
    ones_l = 0;
    ones_r = 0;
    repeat (cycles) begin
      @(negedge clk_114);
      ones_l += int'(audio_l);
      ones_r += int'(audio_r);
    end
  endtask

  ////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////

  always begin : memory_model
    int wait_cycles;
    @(negedge clk_114);
    if (!mem_req && !aux_enable) begin
      exp_off = '0;  // Stream restarts at window base
    end
    if (mem_req) begin
      req_count++;
      check_value("mem_addr", int'(mem_addr), int'(AUX_PAGE) * 65536 + int'(exp_off), 0);
      check_value("buffer_half", int'(buffer_half), int'(exp_off[15]), 0);
      wait_cycles = rand_range(1, 6);  // Access latency
      repeat (wait_cycles) @(negedge clk_114);
      for (int i = 0; i < int'(BURST_LEN); i++) begin
        mem_fill = 1'b1;
        mem_data = fill_word;
        @(negedge clk_114);
        mem_fill = 1'b0;
        wait_cycles = rand_range(0, 2);  // Gaps between fills
        repeat (wait_cycles) @(negedge clk_114);
      end
      req_done++;
      exp_off = exp_off + buf_offset_t'(BURST_LEN);
    end
  end

  ////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
    $display("FAIL: see errors above");
    $finish;
  end

  ////////////////////////////////////////
  // Stimulus and checks
  ////////////////////////////////////////

  initial begin : stimulus
    int ones_l;
    int ones_r;
    int done0;
    int window;
    int mix_l;
    int mix_r;
    rst          = 1'b1;
    aux_enable   = 1'b0;
    native_left  = sample_t'(16'sh8000);  // Most negative, u = 0
    native_right = sample_t'(16'sh8000);
    window       = 8 * int'(SAMPLE_DIV);
    repeat (10) @(negedge clk_114);
    rst = 1'b0;

    $display("test 1: reset state");
    repeat (SAMPLE_DIV) begin
      @(negedge clk_114);
      check_value("mem_req", int'(mem_req), 0, 0);
      check_value("audio_l", int'(audio_l), 0, 0);
      check_value("audio_r", int'(audio_r), 0, 0);
    end

    $display("test 4: native-only density");
    native_left  = sample_t'(rand_range(-32768, 32767));
    native_right = sample_t'(rand_range(-32768, 32767));
    repeat (SAMPLE_DIV) @(negedge clk_114);  // Settle
    count_ones(window, ones_l, ones_r);
    check_value("audio_l ones", ones_l, expected_ones(native_left, window), 1);
    check_value("audio_r ones", ones_r, expected_ones(native_right, window), 1);

    $display("test 2: fetch addressing");
    aux_enable = 1'b1;
    while (req_done < 4) @(negedge clk_114);  // Model checks each address

    $display("test 3: consumption pace");
    @(posedge clk_114);
    done0 = req_done;  // Model moves its burst count on falling edges
    repeat (K_PERIODS * int'(SAMPLE_DIV)) @(posedge clk_114);
    check_value("words fetched", (req_done - done0) * int'(BURST_LEN), 2 * K_PERIODS,
                int'(FIFO_DEPTH + BURST_LEN));
    @(negedge clk_114);

    $display("test 5: mixed density with saturation");
    while (mem_req) @(negedge clk_114);  // Flush only between bursts
    aux_enable   = 1'b0;
    fill_word    = MIX_WORD;
    native_left  = sample_t'(rand_range(20000, 32767));   // Clamps high
    native_right = sample_t'(rand_range(-20000, 10000));  // Stays in range
    repeat (40) @(negedge clk_114);
    aux_enable = 1'b1;
    repeat (2 * int'(SAMPLE_DIV) + 8) @(negedge clk_114);
    mix_l = sat_sum(int'(native_left), int'(byte_swap(MIX_WORD)));
    mix_r = sat_sum(int'(native_right), int'(byte_swap(MIX_WORD)));
    count_ones(window, ones_l, ones_r);
    check_value("audio_l ones", ones_l, expected_ones(sample_t'(mix_l), window), 1);
    check_value("audio_r ones", ones_r, expected_ones(sample_t'(mix_r), window), 1);

    $display("done: %0d checks, %0d errors, %0d assertion failures, %0d requests",
             checks, errors, DUT.u_assert.fail_count, req_count);
    if (errors == 0 && DUT.u_assert.fail_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* filelist.f */
verilog/aux_audio_pkg.sv
verilog/aux_sample_fifo.sv
verilog/aux_sample_sequencer.sv
verilog/audio_mixer.sv
verilog/sigma_delta_dac.sv
verilog/aux_audio_top.sv
test/aux_audio_assert.sv
test/aux_audio_tb.sv

/* Makefile */
TOP := aux_audio_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir
